// File: Bender.yml
package:
  name: pad_port

sources:
  - verilog/pad_pkg.sv
  - verilog/port_pkg.sv
  - verilog/mouse_tracker.sv
  - verilog/port_sequencer.sv
  - verilog/nibble_select.sv
  - verilog/pad_port_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/pad_port_tb.sv

// File: bench/clock_gen.sv
// ==================================================
// Testbench clock and reset generator
// ==================================================

`timescale 1ns/10ps

module clock_gen #(
	parameter int unsigned PERIOD_NS    = 100,
	parameter int unsigned RESET_CYCLES = 5
) (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Synchronous reset, released on a rising edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst <= 1'b0;
	end

endmodule

// File: bench/pad_port_tb.sv
// ==================================================
// Testbench for the console controller port
// Directed tests of pads, multitap, banks and mouse
// ==================================================

`timescale 1ns/10ps

module pad_port_tb
	import pad_pkg::*;
();

	localparam int unsigned CLK_PERIOD    = 100;
	localparam int unsigned RESET_CYCLES  = 5;
	localparam int unsigned MOUSE_TIMEOUT = 64;
	localparam int unsigned HOLD_CYCLES   = 3;
	localparam int unsigned IDLE_CYCLES   = MOUSE_TIMEOUT + 16;  // Past the mouse timeout
	localparam int unsigned PAD_ROUNDS    = 4;
	localparam logic [31:0] RANDOM_SEED   = 32'h3a1e2859;

	// ==================================================
	// Run length, in line steps of one drive and one read
	// ==================================================
	localparam int unsigned STEP_CYCLES   = HOLD_CYCLES + 2;
	localparam int unsigned CLEAR_STEPS   = 6;
	localparam int unsigned PAD_STEPS     = 3 + PAD_ROUNDS * 6;
	localparam int unsigned TAP_STEPS     = 4 + 8 * 2;
	localparam int unsigned BANK_STEPS    = 18;
	localparam int unsigned MOUSE_STEPS   = 4 + 5 * 4;
	localparam int unsigned TIMEOUT_STEPS = 4 + 4 * 4;
	localparam int unsigned RUN_CYCLES    = RESET_CYCLES + 3 * IDLE_CYCLES
		+ STEP_CYCLES * (CLEAR_STEPS + PAD_STEPS + TAP_STEPS + BANK_STEPS
		+ MOUSE_STEPS + TIMEOUT_STEPS);
	localparam int unsigned WATCHDOG_CYCLES = RUN_CYCLES + 200;

	// Mouse movement reports, bit 8 is ignored by the port
	localparam logic [8:0] X1 = 9'h035;
	localparam logic [8:0] Y1 = 9'h0C7;
	localparam logic [8:0] X2 = 9'h1E2;
	localparam logic [8:0] Y2 = 9'h04B;
	localparam logic [8:0] X3 = 9'h0A7;
	localparam logic [8:0] Y3 = 9'h1D6;

	logic       clk_sys;
	logic       rst;
	pad_word_t  joy_a;
	pad_word_t  joy_b;
	pad_word_t  joy_2;
	pad_word_t  joy_3;
	pad_word_t  joy_4;
	logic [8:0] mouse_x;
	logic [8:0] mouse_y;
	logic [1:0] mouse_btn;
	logic       mouse_strobe;
	logic       joy_swap;
	logic       turbotap;
	logic       buttons6;
	logic       mouse_en;
	logic [1:0] joy_out;  // Clear, select
	nibble_t    joy_in;

	int unsigned error_count = 0;
	int unsigned check_count = 0;

	clock_gen #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) clock_gen_i (
		.clk_sys (clk_sys),
		.rst     (rst)
	);

	pad_port_top #(
		.MOUSE_TIMEOUT (MOUSE_TIMEOUT)
	) dut_i (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_btn    (mouse_btn),
		.mouse_strobe (mouse_strobe),
		.joy_swap     (joy_swap),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.mouse_en     (mouse_en),
		.joy_out      (joy_out),
		.joy_in       (joy_in)
	);

	// ==================================================
	// Expected values
	// ==================================================

	// One nibble of a pad's port word, all fields active low
	function automatic nibble_t pad_nibble(input pad_word_t pad, input int idx);
		case (idx)
			0:       return ~pad[7:4];
			1:       return ~{pad[1], pad[2], pad[0], pad[3]};  // Left, down, right, up
			2:       return ~pad[11:8];
			default: return 4'h0;
		endcase
	endfunction

	function automatic nibble_t mouse_button_nibble(input pad_word_t pad, input logic [1:0] btn);
		return ~{pad[7], pad[6], btn[0], btn[1]};
	endfunction

	// Movement nibble read in a given phase, X high first
	function automatic nibble_t mouse_read_nibble(input logic [8:0] x, input logic [8:0] y,
		input int phase);
		logic [7:0] neg_x;
		neg_x = 8'd0 - x[7:0];
		case (phase)
			0:       return neg_x[7:4];
			1:       return neg_x[3:0];
			2:       return y[7:4];
			default: return y[3:0];
		endcase
	endfunction

	// ==================================================
	// Drive and check helpers
	// ==================================================
	task automatic check_value(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic read_check(input string name, input nibble_t expected);
		@(negedge clk_sys);
		check_value(name, expected, joy_in);
	endtask

	task automatic set_lines(input logic sel, input logic clr);
		@(posedge clk_sys);
		joy_out <= {clr, sel};
		repeat (HOLD_CYCLES) @(posedge clk_sys);
	endtask

	// Clear high, checked for zero, then released
	task automatic clear_pulse(input string name, input logic sel);
		set_lines(sel, 1'b1);
		read_check({name, " during clear"}, 4'h0);
		set_lines(sel, 1'b0);
	endtask

	task automatic set_options(input logic swap, input logic tap, input logic six,
		input logic mouse);
		@(posedge clk_sys);
		joy_swap <= swap;
		turbotap <= tap;
		buttons6 <= six;
		mouse_en <= mouse;
	endtask

	task automatic random_pads();
		@(posedge clk_sys);
		joy_a <= $urandom();
		joy_b <= $urandom();
		joy_2 <= $urandom();
		joy_3 <= $urandom();
		joy_4 <= $urandom();
	endtask

	task automatic strobe_mouse(input logic [8:0] x, input logic [8:0] y);
		@(posedge clk_sys);
		mouse_x      <= x;
		mouse_y      <= y;
		mouse_strobe <= 1'b1;
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic test_reset_clear();
		@(negedge clk_sys);
		check_value("after reset", 4'h0, joy_in);
		random_pads();
		set_lines(1'b0, 1'b1);
		read_check("clear, select low", 4'h0);
		set_lines(1'b1, 1'b1);
		read_check("clear, select high", 4'h0);
		set_options(1'b1, 1'b1, 1'b0, 1'b0);
		repeat (HOLD_CYCLES) @(posedge clk_sys);
		read_check("clear, swap and multitap", 4'h0);
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_single_pad();
		int round;
		clear_pulse("single pad", 1'b0);
		for (round = 0; round < PAD_ROUNDS; round++) begin
			random_pads();
			set_options(1'b0, 1'b0, 1'b0, 1'b0);
			set_lines(1'b0, 1'b0);
			read_check("single pad buttons", pad_nibble(joy_a, 0));
			set_lines(1'b1, 1'b0);
			read_check("single pad directions", pad_nibble(joy_a, 1));
			set_options(1'b1, 1'b0, 1'b0, 1'b0);  // Port 0 now shows joy_b
			set_lines(1'b0, 1'b0);
			read_check("swapped pad buttons", pad_nibble(joy_b, 0));
			set_lines(1'b1, 1'b0);
			read_check("swapped pad directions", pad_nibble(joy_b, 1));
		end
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_multitap();
		int        port;
		nibble_t   exp_hi;
		nibble_t   exp_lo;
		pad_word_t pads [PAD_COUNT];
		set_options(1'b0, 1'b1, 1'b0, 1'b0);
		random_pads();
		@(negedge clk_sys);
		pads = '{joy_a, joy_b, joy_2, joy_3, joy_4};
		clear_pulse("multitap", 1'b1);  // Select stays high, port 0
		for (port = 0; port < 8; port++) begin
			if (port != 0) begin
				set_lines(1'b1, 1'b0);  // Select rise, next port
			end
			if (port < PAD_COUNT) begin
				exp_hi = pad_nibble(pads[port], 1);
				exp_lo = pad_nibble(pads[port], 0);
			end else begin
				exp_hi = EMPTY_PORT_WORD[7:4];
				exp_lo = EMPTY_PORT_WORD[3:0];
			end
			read_check($sformatf("multitap port %0d directions", port), exp_hi);
			set_lines(1'b0, 1'b0);
			read_check($sformatf("multitap port %0d buttons", port), exp_lo);
		end
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_six_button();
		set_options(1'b0, 1'b0, 1'b1, 1'b0);
		random_pads();
		clear_pulse("bank 1", 1'b0);
		read_check("bank 1 extra buttons", pad_nibble(joy_a, 2));
		set_lines(1'b1, 1'b0);
		read_check("bank 1 select high", 4'h0);
		clear_pulse("bank 0", 1'b0);
		read_check("bank 0 buttons", pad_nibble(joy_a, 0));
		set_lines(1'b1, 1'b0);
		read_check("bank 0 directions", pad_nibble(joy_a, 1));
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		clear_pulse("six-button off", 1'b0);
		read_check("six-button off buttons", pad_nibble(joy_a, 0));
		clear_pulse("six-button off again", 1'b0);
		read_check("six-button off buttons again", pad_nibble(joy_a, 0));
		set_lines(1'b1, 1'b0);
		read_check("six-button off directions", pad_nibble(joy_a, 1));
	endtask

	task automatic test_mouse_sequence();
		int phase;
		set_options(1'b0, 1'b0, 1'b0, 1'b1);
		random_pads();
		@(posedge clk_sys);
		mouse_btn <= 2'($urandom());
		set_lines(1'b1, 1'b0);
		repeat (IDLE_CYCLES) @(posedge clk_sys);  // Rewind to the last phase
		strobe_mouse(X1, Y1);
		for (phase = 0; phase < 4; phase++) begin
			clear_pulse("mouse", 1'b1);
			read_check($sformatf("mouse phase %0d", phase), mouse_read_nibble(X1, Y1, phase));
			set_lines(1'b0, 1'b0);
			read_check("mouse buttons", mouse_button_nibble(joy_a, mouse_btn));
		end
		clear_pulse("mouse handover", 1'b1);
		read_check("mouse pending cleared", 4'h0);
	endtask

	task automatic test_mouse_timeout();
		set_lines(1'b1, 1'b0);
		repeat (IDLE_CYCLES) @(posedge clk_sys);
		strobe_mouse(X2, Y2);
		clear_pulse("timeout", 1'b1);
		read_check("partial x high", mouse_read_nibble(X2, Y2, 0));
		clear_pulse("timeout", 1'b1);
		read_check("partial x low", mouse_read_nibble(X2, Y2, 1));
		strobe_mouse(X3, Y3);
		repeat (IDLE_CYCLES) @(posedge clk_sys);  // Clear low past the timeout
		clear_pulse("after timeout", 1'b1);
		read_check("restart x high", mouse_read_nibble(X3, Y3, 0));
		clear_pulse("after timeout", 1'b1);
		read_check("restart x low", mouse_read_nibble(X3, Y3, 1));
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================
	initial begin
		int unsigned seed_value;
		joy_a        = '0;
		joy_b        = '0;
		joy_2        = '0;
		joy_3        = '0;
		joy_4        = '0;
		mouse_x      = '0;
		mouse_y      = '0;
		mouse_btn    = '0;
		mouse_strobe = 1'b0;
		joy_swap     = 1'b0;
		turbotap     = 1'b0;
		buttons6     = 1'b0;
		mouse_en     = 1'b0;
		joy_out      = 2'b00;
		seed_value   = $urandom(RANDOM_SEED);
		@(negedge rst);
		test_reset_clear();
		test_single_pad();
		test_multitap();
		test_six_button();
		test_mouse_sequence();
		test_mouse_timeout();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog.f
verilog/pad_pkg.sv
verilog/port_pkg.sv
verilog/mouse_tracker.sv
verilog/port_sequencer.sv
verilog/nibble_select.sv
verilog/pad_port_top.sv
bench/clock_gen.sv
bench/pad_port_tb.sv

// File: verilog/mouse_tracker.sv
// ==================================================
// Mouse movement capture and four-phase nibble read
// ==================================================

`timescale 1ns/10ps

module mouse_tracker
	import pad_pkg::*;
	import port_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic [8:0] mouse_x,
	input  logic [8:0] mouse_y,
	input  logic       mouse_strobe,
	input  logic       phase_step,
	input  logic       phase_rewind,
	output nibble_t    mouse_nibble
);

	mouse_phase_t phase;
	mouse_delta_t pend_x;
	mouse_delta_t pend_y;
	mouse_delta_t shown_x;
	mouse_delta_t shown_y;
	logic         handover;

	// Last nibble read, latch the next pair
	assign handover = phase_step && (phase == MOUSE_Y_LOW);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase   <= MOUSE_Y_LOW;
			pend_x  <= '0;
			pend_y  <= '0;
			shown_x <= '0;
			shown_y <= '0;
		end else begin
			if (phase_rewind) begin
				phase <= MOUSE_Y_LOW;
			end else if (phase_step) begin
				phase <= mouse_phase_t'(phase + 2'd1);
			end

			if (handover) begin
				shown_x <= pend_x;
				shown_y <= pend_y;
				pend_x  <= '0;
				pend_y  <= '0;
			end

			// A fresh report overrides the clear above
			if (mouse_strobe) begin
				pend_x <= mouse_delta_t'(8'd0 - mouse_x[7:0]);  // Console X is inverted
				pend_y <= mouse_delta_t'(mouse_y[7:0]);
			end
		end
	end

	always_comb begin
		case (phase)
			MOUSE_X_HIGH: mouse_nibble = shown_x[7:4];
			MOUSE_X_LOW:  mouse_nibble = shown_x[3:0];
			MOUSE_Y_HIGH: mouse_nibble = shown_y[7:4];
			default:      mouse_nibble = shown_y[3:0];
		endcase
	end

	// Step comes from a clear edge, rewind only while clear is low
	a_step_rewind_excl: assert property (
		@(posedge clk_sys) disable iff (rst)
		!(phase_step && phase_rewind)
	) else $error("mouse phase stepped and rewound in the same cycle");

endmodule

// File: verilog/nibble_select.sv
// ==================================================
// Pad encoding and nibble selection for the console
// Swap, mouse substitution, registered output
// ==================================================

`timescale 1ns/10ps

module nibble_select
	import pad_pkg::*;
	import port_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  pad_word_t   joy_a,
	input  pad_word_t   joy_b,
	input  pad_word_t   joy_2,
	input  pad_word_t   joy_3,
	input  pad_word_t   joy_4,
	input  logic        joy_swap,
	input  logic        mouse_en,
	input  logic [1:0]  mouse_btn,
	input  nibble_t     mouse_nibble,
	input  port_idx_t   port_idx,
	input  nibble_idx_t nibble_idx,
	input  logic [1:0]  joy_out,
	output nibble_t     joy_in
);

	// Pack one pad into the active-low port layout
	function automatic port_word_t encode_pad(input pad_word_t pad);
		port_word_t word;
		word[3:0]   = ~pad[PAD_BTN_LSB +: 4];
		word[7:4]   = ~{pad[PAD_LEFT], pad[PAD_DOWN], pad[PAD_RIGHT], pad[PAD_UP]};
		word[11:8]  = ~pad[PAD_EXT_LSB +: 4];
		word[15:12] = 4'h0;
		return word;
	endfunction

	pad_word_t  joy_0;
	pad_word_t  joy_1;
	logic [7:0] mouse_byte;
	port_word_t pad_words [PAD_COUNT];
	port_word_t sel_word;
	nibble_t    sel_nibble;

	// ==================================================
	// Swap and encode
	// ==================================================
	assign joy_0 = joy_swap ? joy_b : joy_a;
	assign joy_1 = joy_swap ? joy_a : joy_b;

	// Low nibble is Run, Select and the two mouse buttons
	assign mouse_byte[3:0] = ~{joy_0[PAD_RUN], joy_0[PAD_SELECT], mouse_btn[0], mouse_btn[1]};
	assign mouse_byte[7:4] = mouse_nibble;

	assign pad_words[0] = mouse_en ? {mouse_byte, mouse_byte} : encode_pad(joy_0);
	assign pad_words[1] = encode_pad(joy_1);
	assign pad_words[2] = encode_pad(joy_2);
	assign pad_words[3] = encode_pad(joy_3);
	assign pad_words[4] = encode_pad(joy_4);

	// ==================================================
	// Port and nibble select
	// ==================================================
	always_comb begin
		if (port_idx < PAD_COUNT) begin
			sel_word = pad_words[port_idx];
		end else begin
			sel_word = EMPTY_PORT_WORD;  // Nothing plugged in
		end
	end

	assign sel_nibble = sel_word[{nibble_idx, 2'b00} +: 4];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			joy_in <= '0;
		end else if (joy_out[1]) begin
			joy_in <= '0;  // Console reads zero during clear
		end else begin
			joy_in <= sel_nibble;
		end
	end

	a_clear_reads_zero: assert property (
		@(posedge clk_sys) disable iff (rst)
		joy_out[1] |=> (joy_in == '0)
	) else $error("joy_in not zero after clear");

endmodule

// File: verilog/pad_pkg.sv
// ==================================================
// Pad definitions for the console controller port
// Host joystick word, encoded port word, nibble
// ==================================================

package pad_pkg;

	// ==================================================
	// Raw host joystick word, active high
	// ==================================================
	typedef logic [31:0] pad_word_t;

	// Direction bits
	localparam int unsigned PAD_RIGHT = 0;
	localparam int unsigned PAD_LEFT  = 1;
	localparam int unsigned PAD_DOWN  = 2;
	localparam int unsigned PAD_UP    = 3;

	// Button groups, four bits each
	localparam int unsigned PAD_BTN_LSB = 4;  // I, II, Select, Run
	localparam int unsigned PAD_EXT_LSB = 8;  // Six-button extras

	// Select and Run, also reported in mouse mode
	localparam int unsigned PAD_SELECT = 6;
	localparam int unsigned PAD_RUN    = 7;

	// ==================================================
	// Encoded port word, all fields active low
	// ==================================================
	// Nibble 0  ~buttons
	// Nibble 1  ~{left, down, right, up}
	// Nibble 2  ~extra buttons
	// Nibble 3  zero
	typedef logic [15:0] port_word_t;

	typedef logic [3:0] nibble_t;  // One read by the console

	localparam int unsigned PAD_COUNT = 5;  // Multitap ports

	// Ports past the last pad read as nothing pressed
	localparam port_word_t EMPTY_PORT_WORD = 16'h0FFF;

endpackage

// File: verilog/pad_port_top.sv
// ==================================================
// Console controller port, pads and mouse to nibbles
// ==================================================

`timescale 1ns/10ps

module pad_port_top
	import pad_pkg::*;
	import port_pkg::*;
#(
	parameter int unsigned MOUSE_TIMEOUT = MOUSE_TIMEOUT_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       rst,
	input  pad_word_t  joy_a,
	input  pad_word_t  joy_b,
	input  pad_word_t  joy_2,
	input  pad_word_t  joy_3,
	input  pad_word_t  joy_4,
	input  logic [8:0] mouse_x,
	input  logic [8:0] mouse_y,
	input  logic [1:0] mouse_btn,
	input  logic       mouse_strobe,
	input  logic       joy_swap,
	input  logic       turbotap,
	input  logic       buttons6,
	input  logic       mouse_en,
	input  logic [1:0] joy_out,
	output nibble_t    joy_in
);

	port_idx_t   port_idx;
	nibble_idx_t nibble_idx;
	logic        phase_step;
	logic        phase_rewind;
	nibble_t     mouse_nibble;

	port_sequencer #(
		.MOUSE_TIMEOUT (MOUSE_TIMEOUT)
	) port_sequencer_i (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.joy_out      (joy_out),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.port_idx     (port_idx),
		.nibble_idx   (nibble_idx),
		.phase_step   (phase_step),
		.phase_rewind (phase_rewind)
	);

	mouse_tracker mouse_tracker_i (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.phase_step   (phase_step),
		.phase_rewind (phase_rewind),
		.mouse_nibble (mouse_nibble)
	);

	nibble_select nibble_select_i (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.joy_swap     (joy_swap),
		.mouse_en     (mouse_en),
		.mouse_btn    (mouse_btn),
		.mouse_nibble (mouse_nibble),
		.port_idx     (port_idx),
		.nibble_idx   (nibble_idx),
		.joy_out      (joy_out),
		.joy_in       (joy_in)
	);

endmodule

// File: verilog/port_pkg.sv
// ==================================================
// Port sequencing types for the controller port
// Multitap index, nibble index, mouse read phase
// ==================================================

package port_pkg;

	// Multitap port number, wraps at 8
	typedef logic [2:0] port_idx_t;

	// Nibble within a port word
	// High bit is the six-button bank, low bit is select
	typedef logic [1:0] nibble_idx_t;

	// ==================================================
	// Mouse
	// ==================================================

	// One phase per clear pulse, in read order
	typedef enum logic [1:0] {
		MOUSE_X_HIGH = 2'd0,
		MOUSE_X_LOW  = 2'd1,
		MOUSE_Y_HIGH = 2'd2,
		MOUSE_Y_LOW  = 2'd3
	} mouse_phase_t;

	typedef logic signed [7:0] mouse_delta_t;  // Movement since last handover

	// Cycles with clear low before the phase rewinds
	localparam int unsigned MOUSE_TIMEOUT_DEFAULT = 32767;

endpackage

// File: verilog/port_sequencer.sv
// ==================================================
// Select and clear edge tracking for the pad port
// Multitap port, six-button bank, mouse idle timeout
// ==================================================

`timescale 1ns/10ps

module port_sequencer
	import port_pkg::*;
#(
	parameter int unsigned MOUSE_TIMEOUT = MOUSE_TIMEOUT_DEFAULT
) (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic [1:0]  joy_out,
	input  logic        turbotap,
	input  logic        buttons6,
	output port_idx_t   port_idx,
	output nibble_idx_t nibble_idx,
	output logic        phase_step,
	output logic        phase_rewind
);

	localparam int unsigned     TO_W    = $clog2(MOUSE_TIMEOUT + 1);
	localparam logic [TO_W-1:0] TO_LAST = TO_W'(MOUSE_TIMEOUT);

	logic            sel;
	logic            clr;
	logic            sel_q;
	logic            clr_q;
	logic            sel_rise;
	logic            clr_rise;
	logic            bank;
	logic [TO_W-1:0] idle_cnt;
	logic [TO_W-1:0] idle_next;

	assign sel = joy_out[0];
	assign clr = joy_out[1];

	assign sel_rise = sel && !sel_q;
	assign clr_rise = clr && !clr_q;

	// ==================================================
	// Edge history
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sel_q <= 1'b0;
			clr_q <= 1'b0;
		end else begin
			sel_q <= sel;
			clr_q <= clr;
		end
	end

	// ==================================================
	// Multitap port and button bank
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			port_idx <= '0;
		end else if (clr) begin
			port_idx <= '0;  // Clear restarts the scan at port 0
		end else if (sel_rise && turbotap) begin
			port_idx <= port_idx + 3'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst || !buttons6) begin
			bank <= 1'b0;
		end else if (clr_rise) begin
			bank <= !bank;
		end
	end

	// Select picks the nibble directly, no extra stage
	assign nibble_idx = {bank, sel};

	// ==================================================
	// Mouse phase step and idle timeout
	// ==================================================
	always_comb begin
		if (clr) begin
			idle_next = '0;
		end else if (idle_cnt == TO_LAST) begin
			idle_next = idle_cnt;  // Saturate
		end else begin
			idle_next = idle_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			idle_cnt     <= '0;
			phase_step   <= 1'b0;
			phase_rewind <= 1'b0;
		end else begin
			idle_cnt     <= idle_next;
			phase_step   <= clr_rise;
			phase_rewind <= !clr && (idle_next == TO_LAST);
		end
	end

	a_clear_port_zero: assert property (
		@(posedge clk_sys) disable iff (rst)
		clr |=> (port_idx == '0)
	) else $error("multitap port not at 0 after clear");

endmodule
